/* project.f */
verilog/op_pkg.sv
verilog/op_regs.sv
verilog/op_wbk.sv
verilog/op_line_seq.sv
verilog/op_top.sv
bench/op_wbk_chk.sv
bench/op_tb.sv

/* bench/op_tb.sv */
`default_nettype none
`timescale 1ns/10ps
// ############################################################
// Object write-back testbench
// ############################################################

module op_tb;

	// Rough cycle count of all tests
	localparam int TEST_CYCLES = 2000;

	logic                        sys_clk;
	logic                        resetl;
	logic                        wb_cyc;
	logic                        wb_stb;
	logic                        wb_we;
	logic [op_pkg::WB_AW-1:0]    wb_adr;
	logic [31:0]                 wb_dat_i;
	logic [31:0]                 wb_dat_o;
	logic                        wb_ack;
	// Reference model state
	logic [op_pkg::DATA_W-1:0]   m_data;
	logic [op_pkg::HEIGHT_W-1:0] m_height;
	logic [op_pkg::HEIGHT_W-1:0] m_lines;
	logic [op_pkg::DWIDTH_W-1:0] m_dwidth;
	logic [op_pkg::REM_W-1:0]    m_vscale;
	logic                        m_scaled;
	int                          m_rem;

	op_top DUT (.sys_clk(sys_clk), .resetl(resetl), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
		.wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o),
		.wb_ack(wb_ack));

	bind op_wbk op_wbk_chk u_wbk_chk (.sys_clk(sys_clk), .resetl(resetl), .state(state),
		.wbkstart(wbkstart), .step(step), .obld_0(obld_0), .newheight(newheight));

	always #50 sys_clk = ~sys_clk;

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "Stopped at first error");
	endtask

	// Ack is sampled on the falling edge where it is stable
	task automatic wait_ack();
		int n;
		n = 0;
		while (!wb_ack) begin
			@(negedge sys_clk);
			n++;
			if (n > 8) abort_run("No Wishbone ack within 8 cycles");
		end
	endtask

	// One idle cycle after each access lets loads settle
	task automatic wb_write(input logic [op_pkg::WB_AW-1:0] adr, input logic [31:0] dat);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_dat_i = dat;
		wait_ack();
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(negedge sys_clk);
	endtask

	// Read data is valid in the ack cycle
	task automatic wb_read(input logic [op_pkg::WB_AW-1:0] adr, output logic [31:0] dat);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		wait_ack();
		dat    = wb_dat_o;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		@(negedge sys_clk);
	endtask

	task automatic check_data(input string name, input logic [op_pkg::DATA_W-1:0] got,
		input logic [op_pkg::DATA_W-1:0] exp);
		if (got !== exp) abort_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_height(input string name, input logic [op_pkg::HEIGHT_W-1:0] got,
		input logic [op_pkg::HEIGHT_W-1:0] exp);
		if (got !== exp) abort_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_rem(input string name, input logic [op_pkg::REM_W-1:0] got,
		input logic [op_pkg::REM_W-1:0] exp);
		if (got !== exp) abort_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_status(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) abort_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// Scaled passes drop 1.0 then skip lines while the integer part is <= 0
	function automatic void model_pass();
		if (!m_scaled) begin
			m_data   = m_data + m_dwidth;
			m_height = m_height - 1'b1;
		end else begin
			m_rem = m_rem - 32;
			while (m_height != 0 && m_rem < 32) begin
				m_rem    = m_rem + m_vscale;
				m_data   = m_data + m_dwidth;
				m_height = m_height - 1'b1;
			end
		end
	endfunction

	// Passes stop at the count or once the height runs out
	function automatic void model_run(input int n);
		m_lines = '0;
		for (int i = 0; i < n && m_height != 0; i++) begin
			model_pass();
			m_lines = m_lines + 1'b1;
		end
	endfunction

	// Control register and its model copy
	task automatic set_ctrl(input logic s, input logic [9:0] dw, input logic [7:0] vs);
		wb_write(op_pkg::REG_CTRL, {s, 5'h0, dw, 8'h0, vs});
		m_scaled = s;
		m_dwidth = dw;
		m_vscale = vs;
	endtask

	// Reserved phrase bits get random filler
	task automatic load_object(input logic [20:0] data, input logic [9:0] h, input logic [7:0] r);
		op_pkg::ob_phrase_t ph;
		ph            = {$urandom, $urandom};
		ph.ph0.data   = data;
		ph.ph0.height = h;
		wb_write(op_pkg::REG_P0_LO, ph[31:0]);
		wb_write(op_pkg::REG_P0_HI, ph[63:32]);
		ph            = {$urandom, $urandom};
		ph.ph2.rem    = r;
		wb_write(op_pkg::REG_P2_LO, ph[31:0]);
		m_data   = data;
		m_height = h;
		m_rem    = r;
	endtask

	// Poll busy until the line run ends
	task automatic wait_idle();
		logic [31:0] st;
		int          polls;
		polls = 0;
		do begin
			wb_read(op_pkg::REG_STATUS, st);
			polls++;
			if (polls > 400) abort_run("Line run still busy after 400 status polls");
		end while (st[31]);
	endtask

	task automatic run_lines(input int n);
		wb_write(op_pkg::REG_CMD, 32'(n));
		wait_idle();
		model_run(n);
	endtask

	// Readback of all updated fields against the model
	task automatic compare_model();
		logic [31:0] rd;
		wb_read(op_pkg::REG_DATA, rd);
		check_data("newdata", rd[20:0], m_data);
		wb_read(op_pkg::REG_HREM, rd);
		check_height("newheight", rd[25:16], m_height);
		check_rem("newrem", rd[7:0], 8'(m_rem));
		wb_read(op_pkg::REG_STATUS, rd);
		check_status("status", rd, {1'b0, m_height != 0, 20'h0, m_lines});
	endtask

	task automatic test_reset_and_ctrl();
		logic [31:0] v;
		logic [31:0] rd;
		compare_model();
		v = $urandom;
		wb_write(op_pkg::REG_CTRL, v);
		wb_read(op_pkg::REG_CTRL, rd);
		check_status("ctrl", rd, v & 32'h83FF_00FF);
	endtask

	task automatic test_runs();
		load_object(21'($urandom), 10'(16 + $urandom % 100), 8'($urandom));
		compare_model();
		// Unscaled run of several lines
		set_ctrl(1'b0, 10'($urandom), 8'h0);
		load_object(21'($urandom), 10'(40 + $urandom % 50), 8'($urandom));
		run_lines(1 + $urandom % 12);
		compare_model();
		// Scaled, one line per command
		repeat (6) begin
			set_ctrl(1'b1, 10'($urandom), 8'(8 + $urandom % 57));
			load_object(21'($urandom), 10'(60 + $urandom % 60), 8'($urandom));
			repeat (3) begin
				run_lines(1);
				compare_model();
			end
		end
	endtask

	task automatic test_early_stop();
		int h;
		h = 2 + $urandom % 6;
		// Lines done must stop at the height
		set_ctrl(1'b0, 10'($urandom), 8'h0);
		load_object(21'($urandom), 10'(h), 8'($urandom));
		run_lines(h + 3);
		compare_model();
		// Scaled object running out of height inside one pass
		set_ctrl(1'b1, 10'($urandom), 8'h08);
		load_object(21'($urandom), 10'd4, 8'h10);
		run_lines(10);
		compare_model();
	endtask

	task automatic test_busy_ignored();
		logic [31:0] rd;
		set_ctrl(1'b0, 10'($urandom), 8'h0);
		load_object(21'($urandom), 10'd60, 8'($urandom));
		wb_write(op_pkg::REG_CMD, 32'd20);
		wb_read(op_pkg::REG_STATUS, rd);
		if (!rd[31]) abort_run("Run not busy right after its command");
		// Loads and a new command while the run is going
		wb_write(op_pkg::REG_P0_LO, $urandom);
		wb_write(op_pkg::REG_P0_HI, $urandom);
		wb_write(op_pkg::REG_P2_LO, $urandom);
		wb_write(op_pkg::REG_CMD, 32'd5);
		wait_idle();
		model_run(20);
		compare_model();
	endtask

	initial begin
		void'($urandom(86));
		sys_clk  = 1'b0;
		resetl   = 1'b0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_i = '0;
		m_data   = '0;
		m_height = '0;
		m_lines  = '0;
		m_rem    = 0;
		m_scaled = 1'b0;
		m_dwidth = '0;
		m_vscale = '0;
		repeat (3) @(negedge sys_clk);
		resetl = 1'b1;
		test_reset_and_ctrl();
		test_runs();
		test_early_stop();
		test_busy_ignored();
		$display("TEST PASS");
		$finish;
	end

	// Watchdog
	initial begin
		#(TEST_CYCLES * 4 * 100);
		abort_run("Watchdog timeout, the tests did not finish in time");
	end

endmodule

`default_nettype wire

/* bench/op_wbk_chk.sv */
`default_nettype none
`timescale 1ns/10ps
// ############################################################
// Write-back FSM assertions
// ############################################################

module op_wbk_chk (
	input wire                         sys_clk,
	input wire                         resetl,
	input wire [2:0]                   state,
	input wire                         wbkstart,
	input wire                         step,
	input wire                         obld_0,
	input wire [op_pkg::HEIGHT_W-1:0]  newheight
);

	// Exactly one state bit set at any time
	a_onehot: assert property (@(posedge sys_clk) disable iff (!resetl) $onehot(state))
		else $error("write-back state is not one-hot");

	// A pass may only start from idle
	a_start_idle: assert property (@(posedge sys_clk) disable iff (!resetl)
		wbkstart |-> state[op_pkg::WBK_IDLE])
		else $error("wbkstart seen outside IDLE");

	// A source line step never takes the height below zero
	a_no_wrap: assert property (@(posedge sys_clk) disable iff (!resetl)
		(step && !obld_0) |-> (newheight != '0))
		else $error("height stepped down from zero");

endmodule

`default_nettype wire

/* verilog/op_top.sv */
`default_nettype none
`timescale 1ns/10ps
// ############################################################
// Object write-back subsystem
// ############################################################

module op_top (
	input  wire                             sys_clk,
	input  wire                             resetl,
	// Wishbone classic slave
	input  wire                             wb_cyc,
	input  wire                             wb_stb,
	input  wire                             wb_we,
	input  wire  [op_pkg::WB_AW-1:0]        wb_adr,
	input  wire  [31:0]                     wb_dat_i,
	output logic [31:0]                     wb_dat_o,
	output logic                            wb_ack
);

	// Register bank to write-back
	op_pkg::ob_phrase_t              phrase;
	logic                            obld_0;
	logic                            obld_2;
	logic                            scaled;
	logic [op_pkg::DWIDTH_W-1:0]     dwidth;
	logic [op_pkg::REM_W-1:0]        vscale;
	// Command path
	logic                            cmd_go;
	logic [op_pkg::HEIGHT_W-1:0]     cmd_lines;
	logic                            wbkstart;
	logic                            wbkdone;
	logic                            busy;
	logic [op_pkg::HEIGHT_W-1:0]     lines_done;
	// Updated fields
	logic                            heightnz;
	logic [op_pkg::DATA_W-1:0]       newdata;
	logic [op_pkg::HEIGHT_W-1:0]     newheight;
	logic [op_pkg::REM_W-1:0]        newrem;

	op_regs u_regs (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_i   (wb_dat_i),
		.wb_dat_o   (wb_dat_o),
		.wb_ack     (wb_ack),
		.phrase     (phrase),
		.obld_0     (obld_0),
		.obld_2     (obld_2),
		.scaled     (scaled),
		.dwidth     (dwidth),
		.vscale     (vscale),
		.cmd_go     (cmd_go),
		.cmd_lines  (cmd_lines),
		.busy       (busy),
		.lines_done (lines_done),
		.heightnz   (heightnz),
		.newdata    (newdata),
		.newheight  (newheight),
		.newrem     (newrem)
	);

	op_wbk u_wbk (
		.sys_clk   (sys_clk),
		.resetl    (resetl),
		.phrase    (phrase),
		.obld_0    (obld_0),
		.obld_2    (obld_2),
		.dwidth    (dwidth),
		.vscale    (vscale),
		.scaled    (scaled),
		.wbkstart  (wbkstart),
		.newdata   (newdata),
		.newheight (newheight),
		.newrem    (newrem),
		.heightnz  (heightnz),
		.wbkdone   (wbkdone)
	);

	op_line_seq u_line_seq (
		.sys_clk    (sys_clk),
		.resetl     (resetl),
		.cmd_go     (cmd_go),
		.cmd_lines  (cmd_lines),
		.wbkdone    (wbkdone),
		.heightnz   (heightnz),
		.wbkstart   (wbkstart),
		.busy       (busy),
		.lines_done (lines_done)
	);

endmodule

`default_nettype wire

/* verilog/op_line_seq.sv */
`default_nettype none
`timescale 1ns/10ps
// ############################################################
// Write-back line sequencer
// ############################################################

module op_line_seq (
	input  wire                             sys_clk,
	input  wire                             resetl,
	// Line command from the host registers
	input  wire                             cmd_go,
	input  wire  [op_pkg::HEIGHT_W-1:0]     cmd_lines,
	// Write-back handshake
	input  wire                             wbkdone,
	input  wire                             heightnz,
	output logic                            wbkstart,
	// Run status
	output logic                            busy,
	output logic [op_pkg::HEIGHT_W-1:0]     lines_done
);

	// Issue or wait for a pass
	logic                        waiting;
	logic [op_pkg::HEIGHT_W-1:0] remaining;
	logic                        pass_end;
	logic                        last_pass;

	// Start only while the write-back block is idle
	assign wbkstart = busy & ~waiting & wbkdone;
	// Idle again after a started pass
	assign pass_end = busy & waiting & wbkdone;
	// Count used up or no height left
	assign last_pass = (remaining == 1'b1) | ~heightnz;

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			busy       <= 1'b0;
			waiting    <= 1'b0;
			remaining  <= '0;
			lines_done <= '0;
		end else if (cmd_go && !busy) begin
			lines_done <= '0;
			remaining  <= cmd_lines;
			waiting    <= 1'b0;
			// Nothing to do for zero lines or an empty object
			busy       <= (cmd_lines != '0) & heightnz;
		end else if (wbkstart) begin
			waiting <= 1'b1;
		end else if (pass_end) begin
			lines_done <= lines_done + 1'b1;
			remaining  <= remaining - 1'b1;
			waiting    <= 1'b0;
			if (last_pass) begin
				busy <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/op_wbk.sv */
`default_nettype none
`timescale 1ns/10ps
// ############################################################
// Scaled object write-back
// ############################################################

module op_wbk (
	input  wire                             sys_clk,
	input  wire                             resetl,
	// Header phrase and its load strobes
	input  wire op_pkg::ob_phrase_t         phrase,
	input  wire                             obld_0,
	input  wire                             obld_2,
	// Line parameters
	input  wire  [op_pkg::DWIDTH_W-1:0]     dwidth,
	input  wire  [op_pkg::REM_W-1:0]        vscale,
	input  wire                             scaled,
	input  wire                             wbkstart,
	// Updated fields
	output logic [op_pkg::DATA_W-1:0]       newdata,
	output logic [op_pkg::HEIGHT_W-1:0]     newheight,
	output logic [op_pkg::REM_W-1:0]        newrem,
	output logic                            heightnz,
	output logic                            wbkdone
);

	// One-hot controller
	logic [2:0]              state;
	logic [2:0]              state_nx;
	// Remainder with one extra sign bit
	logic [op_pkg::REM_W:0]  rem;
	logic [op_pkg::REM_W:0]  rem_delta;
	logic [op_pkg::REM_W:0]  rem_sum;
	// Step controls
	logic                    step;
	logic                    rem_dec;
	logic                    rem_add;
	// Integer part zero or negative
	logic                    intrem_le0;

	assign wbkdone  = state[op_pkg::WBK_IDLE];
	assign heightnz = |newheight;
	assign newrem   = rem[op_pkg::REM_W-1:0];

	// Sign set or integer bits all clear
	assign intrem_le0 = rem[op_pkg::REM_W] | ~(|rem[op_pkg::REM_W-1:5]);

	// Subtract 1.0 on entry, else add the scale back
	assign rem_delta = rem_dec ? ({(op_pkg::REM_W+1){1'b0}} - {1'b0, op_pkg::REM_ONE})
		: {1'b0, vscale};
	assign rem_sum   = rem + rem_delta;

	// Next state and step decode
	always_comb begin
		state_nx = '0;
		step     = 1'b0;
		rem_dec  = 1'b0;
		rem_add  = 1'b0;
		case (1'b1)
			state[op_pkg::WBK_IDLE]: begin
				if (wbkstart) begin
					state_nx[op_pkg::WBK_CHECK] = 1'b1;
				end else begin
					state_nx[op_pkg::WBK_IDLE] = 1'b1;
				end
			end
			state[op_pkg::WBK_CHECK]: begin
				if (scaled) begin
					// One displayed line used up
					rem_dec = 1'b1;
					state_nx[op_pkg::WBK_STEP] = 1'b1;
				end else begin
					// Unscaled objects move one source line
					step = 1'b1;
					state_nx[op_pkg::WBK_IDLE] = 1'b1;
				end
			end
			state[op_pkg::WBK_STEP]: begin
				// Skip source lines until the remainder is positive again
				if (heightnz && intrem_le0) begin
					step    = 1'b1;
					rem_add = 1'b1;
					state_nx[op_pkg::WBK_STEP] = 1'b1;
				end else begin
					state_nx[op_pkg::WBK_IDLE] = 1'b1;
				end
			end
			default: begin
				// Illegal encodings fall back to idle
				state_nx[op_pkg::WBK_IDLE] = 1'b1;
			end
		endcase
	end

	// State, pointer, height and remainder
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			state     <= 3'(1 << op_pkg::WBK_IDLE);
			newdata   <= '0;
			newheight <= '0;
			rem       <= '0;
		end else begin
			state <= state_nx;
			// Phrase 0 carries pointer and height
			if (obld_0) begin
				newdata   <= phrase.ph0.data;
				newheight <= phrase.ph0.height;
			end else if (step) begin
				newdata   <= newdata + {{(op_pkg::DATA_W-op_pkg::DWIDTH_W){1'b0}}, dwidth};
				newheight <= newheight - 1'b1;
			end
			// Phrase 2 carries the remainder
			if (obld_2) begin
				rem <= {1'b0, phrase.ph2.rem};
			end else if (rem_dec || rem_add) begin
				rem <= rem_sum;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/op_regs.sv */
`default_nettype none
`timescale 1ns/10ps
// ############################################################
// Object processor host registers
// ############################################################

module op_regs (
	input  wire                             sys_clk,
	input  wire                             resetl,
	// Wishbone classic slave
	input  wire                             wb_cyc,
	input  wire                             wb_stb,
	input  wire                             wb_we,
	input  wire  [op_pkg::WB_AW-1:0]        wb_adr,
	input  wire  [31:0]                     wb_dat_i,
	output logic [31:0]                     wb_dat_o,
	output logic                            wb_ack,
	// Phrase loads and line parameters
	output op_pkg::ob_phrase_t              phrase,
	output logic                            obld_0,
	output logic                            obld_2,
	output logic                            scaled,
	output logic [op_pkg::DWIDTH_W-1:0]     dwidth,
	output logic [op_pkg::REM_W-1:0]        vscale,
	// Line command
	output logic                            cmd_go,
	output logic [op_pkg::HEIGHT_W-1:0]     cmd_lines,
	// Readback sources
	input  wire                             busy,
	input  wire  [op_pkg::HEIGHT_W-1:0]     lines_done,
	input  wire                             heightnz,
	input  wire  [op_pkg::DATA_W-1:0]       newdata,
	input  wire  [op_pkg::HEIGHT_W-1:0]     newheight,
	input  wire  [op_pkg::REM_W-1:0]        newrem
);

	// Held phrase words
	logic [31:0] p0_lo;
	logic [31:0] p0_hi;
	logic [31:0] p2_lo;
	// Set after ack until the master drops stb
	logic        ack_done;
	logic        req;
	logic        wr;
	logic [31:0] rd_data;

	// New request, sampled once per strobe
	assign req = wb_cyc & wb_stb & ~wb_ack & ~ack_done;
	assign wr  = req & wb_we;

	// Phrase 2 only on its own load strobe
	assign phrase = obld_2 ? {32'h0, p2_lo} : {p0_hi, p0_lo};

	// Handshake, strobes and control register
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			wb_ack    <= 1'b0;
			ack_done  <= 1'b0;
			obld_0    <= 1'b0;
			obld_2    <= 1'b0;
			cmd_go    <= 1'b0;
			scaled    <= 1'b0;
			dwidth    <= '0;
			vscale    <= '0;
			cmd_lines <= '0;
		end else begin
			// Ack one cycle after the request
			wb_ack   <= req;
			// Hold off a second ack while stb stays up
			ack_done <= wb_cyc & wb_stb & (ack_done | wb_ack);
			// Strobes line up with the ack cycle
			// Loads and commands are dropped while a run is going
			obld_0   <= wr & (wb_adr == op_pkg::REG_P0_HI) & ~busy;
			obld_2   <= wr & (wb_adr == op_pkg::REG_P2_LO) & ~busy;
			cmd_go   <= wr & (wb_adr == op_pkg::REG_CMD) & ~busy;
			if (wr && wb_adr == op_pkg::REG_CTRL) begin
				scaled <= wb_dat_i[31];
				dwidth <= wb_dat_i[25:16];
				vscale <= wb_dat_i[7:0];
			end
			// Line count kept for readback
			if (wr && wb_adr == op_pkg::REG_CMD && !busy) begin
				cmd_lines <= wb_dat_i[op_pkg::HEIGHT_W-1:0];
			end
		end
	end

	// Phrase words and read data
	always_ff @(posedge sys_clk) begin
		if (wr && wb_adr == op_pkg::REG_P0_LO) begin
			p0_lo <= wb_dat_i;
		end
		if (wr && wb_adr == op_pkg::REG_P0_HI) begin
			p0_hi <= wb_dat_i;
		end
		if (wr && wb_adr == op_pkg::REG_P2_LO) begin
			p2_lo <= wb_dat_i;
		end
		// Read value is registered for the ack cycle
		if (req) begin
			wb_dat_o <= rd_data;
		end
	end

	// Readback select
	always_comb begin
		case (wb_adr)
			op_pkg::REG_P0_LO:  rd_data = p0_lo;
			op_pkg::REG_P0_HI:  rd_data = p0_hi;
			op_pkg::REG_P2_LO:  rd_data = p2_lo;
			op_pkg::REG_CTRL:   rd_data = {scaled, 5'h0, dwidth, 8'h0, vscale};
			op_pkg::REG_CMD:    rd_data = {22'h0, cmd_lines};
			op_pkg::REG_STATUS: rd_data = {busy, heightnz, 20'h0, lines_done};
			op_pkg::REG_DATA:   rd_data = {11'h0, newdata};
			// Height in the upper half, remainder in the low byte
			op_pkg::REG_HREM:   rd_data = {6'h0, newheight, 8'h0, newrem};
			default:            rd_data = 32'h0;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/op_pkg.sv */
`default_nettype none
// ############################################################
// Object processor shared definitions
// ############################################################

package op_pkg;

	// Field widths of the header phrases
	localparam int DATA_W   = 21;
	localparam int HEIGHT_W = 10;
	// Remainder in 3.5 fixed point
	localparam int REM_W    = 8;
	localparam int DWIDTH_W = 10;

	// 1.0 in 3.5 fixed point
	localparam logic [REM_W-1:0] REM_ONE = 8'h20;

	// Wishbone word address width and register map
	localparam int WB_AW = 3;
	localparam logic [WB_AW-1:0] REG_P0_LO  = 3'd0;
	localparam logic [WB_AW-1:0] REG_P0_HI  = 3'd1;
	localparam logic [WB_AW-1:0] REG_P2_LO  = 3'd2;
	localparam logic [WB_AW-1:0] REG_CTRL   = 3'd3;
	localparam logic [WB_AW-1:0] REG_CMD    = 3'd4;
	localparam logic [WB_AW-1:0] REG_STATUS = 3'd5;
	localparam logic [WB_AW-1:0] REG_DATA   = 3'd6;
	localparam logic [WB_AW-1:0] REG_HREM   = 3'd7;

	// Bit positions of the one-hot write-back state
	localparam int WBK_IDLE  = 0;
	localparam int WBK_CHECK = 1;
	localparam int WBK_STEP  = 2;

	// One header phrase, seen as phrase 0 or phrase 2
	typedef union packed {
		struct packed {
			logic [DATA_W-1:0]   data;
			logic [18:0]         rsvd_hi;
			logic [HEIGHT_W-1:0] height;
			logic [13:0]         rsvd_lo;
		} ph0;
		struct packed {
			logic [39:0]      rsvd_hi;
			logic [REM_W-1:0] rem;
			logic [15:0]      rsvd_lo;
		} ph2;
	} ob_phrase_t;

endpackage

`default_nettype wire
